//--- cluster_periph.f
design/cluster_periph_pkg.sv
design/periph_bus_decoder.sv
design/cluster_ctrl_unit.sv
design/cluster_timer.sv
design/event_unit.sv
design/cluster_periph_top.sv
tests/tb_clock_gen.sv
tests/cluster_periph_sva.sv
tests/cluster_periph_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := cluster_periph_tb
FILELIST  := cluster_periph.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/cluster_periph_tb.sv
// directed testbench for the cluster peripheral subsystem
module cluster_periph_tb;
  import cluster_periph_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 10;
  // rough upper bound of each test in cycles, feeds the watchdog
  localparam int TEST_CYCLES [6] = '{20, 40, 70, 40, 70, 20};

  localparam addr_t CTRL_EOC   = 32'h0000_0000;
  localparam addr_t CTRL_FETCH = 32'h0000_0004;
  localparam addr_t CTRL_BOOT  = 32'h0000_0010;
  localparam addr_t TIMER_CFG  = 32'h0000_0400;
  localparam addr_t TIMER_CNT  = 32'h0000_0404;
  localparam addr_t TIMER_CMP  = 32'h0000_0408;
  localparam addr_t EU_MASK    = 32'h0000_0800;
  localparam addr_t EU_PEND    = 32'h0000_0810;
  localparam addr_t EU_SW      = 32'h0000_0814;
  localparam addr_t UNMAPPED   = 32'h0000_0C00;

  logic                         clk;
  logic                         rst_n;
  logic                         bus_req;
  addr_t                        bus_add;
  logic                         bus_wen;
  data_t                        bus_wdata;
  be_t                          bus_be;
  logic                         fetch_en;
  core_mask_t                   dma_events;
  core_mask_t                   core_busy;
  core_mask_t                   irq_ack;
  irq_id_t [NB_CORES-1:0]       irq_ack_id;
  logic                         bus_gnt;
  logic                         bus_r_valid;
  data_t                        bus_r_rdata;
  logic                         eoc;
  core_mask_t                   fetch_enable;
  addr_t [NB_CORES-1:0]         boot_addr;
  core_mask_t                   irq_req;
  irq_id_t [NB_CORES-1:0]       irq_id;
  core_mask_t                   core_clk_en;
  logic                         busy;

  int    err_cnt;
  int    fail_tests;
  int    test_cnt;
  addr_t boot_model [NB_CORES];
  data_t cmp_n;

  tb_clock_gen clk_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  cluster_periph_top uut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .bus_req_i      ( bus_req      ),
    .bus_add_i      ( bus_add      ),
    .bus_wen_i      ( bus_wen      ),
    .bus_wdata_i    ( bus_wdata    ),
    .bus_be_i       ( bus_be       ),
    .fetch_en_i     ( fetch_en     ),
    .dma_events_i   ( dma_events   ),
    .core_busy_i    ( core_busy    ),
    .irq_ack_i      ( irq_ack      ),
    .irq_ack_id_i   ( irq_ack_id   ),
    .bus_gnt_o      ( bus_gnt      ),
    .bus_r_valid_o  ( bus_r_valid  ),
    .bus_r_rdata_o  ( bus_r_rdata  ),
    .eoc_o          ( eoc          ),
    .fetch_enable_o ( fetch_enable ),
    .boot_addr_o    ( boot_addr    ),
    .irq_req_o      ( irq_req      ),
    .irq_id_o       ( irq_id       ),
    .core_clk_en_o  ( core_clk_en  ),
    .busy_o         ( busy         )
  );

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %-22s ok", name);
    end else begin
      fail_tests++;
      $display("test %-22s failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // write, wen low; the response comes one cycle later and carries zero
  task automatic bus_write(input addr_t addr, input data_t data);
    @(negedge clk);
    bus_req   = 1'b1;
    bus_add   = addr;
    bus_wen   = 1'b0;
    bus_wdata = data;
    bus_be    = 4'hF;
    @(negedge clk);
    bus_req = 1'b0;
    bus_wen = 1'b1;
    assert (bus_r_valid === 1'b1) else begin
      $display("no write response one cycle after the request to 0x%08h", addr);
      err_cnt++;
    end
    check_val("bus_r_rdata_o", bus_r_rdata, 32'h0);
  endtask

  task automatic bus_read(input addr_t addr, output data_t data);
    @(negedge clk);
    bus_req = 1'b1;
    bus_add = addr;
    bus_wen = 1'b1;
    @(negedge clk);
    bus_req = 1'b0;
    assert (bus_r_valid === 1'b1) else begin
      $display("no read response one cycle after the request to 0x%08h", addr);
      err_cnt++;
    end
    data = bus_r_rdata;
  endtask

  // one request per cycle, each response checked while the next request is issued
  task automatic read_in_order(input addr_t addrs[$], input data_t exps[$]);
    for (int i = 0; i <= addrs.size(); i++) begin
      @(negedge clk);
      if (i > 0) begin
        assert (bus_r_valid === 1'b1) else begin
          $display("no response for back-to-back read number %0d", i - 1);
          err_cnt++;
        end
        check_val("bus_r_rdata_o", bus_r_rdata, exps[i-1]);
      end
      if (i < addrs.size()) begin
        bus_req = 1'b1;
        bus_add = addrs[i];
        bus_wen = 1'b1;
      end else begin
        bus_req = 1'b0;
      end
    end
  endtask

  task automatic ack_irq(input core_mask_t cores, input irq_id_t id);
    @(negedge clk);
    irq_ack = cores;
    for (int c = 0; c < NB_CORES; c++) begin
      irq_ack_id[c] = id;
    end
    @(negedge clk);
    irq_ack = '0;
  endtask

  task automatic write_masks(input core_mask_t cores, input data_t mask);
    for (int c = 0; c < NB_CORES; c++) begin
      bus_write(EU_MASK + addr_t'(4 * c), cores[c] ? mask : 32'h0);
    end
  endtask

  task automatic test_reset_values();
    int    e;
    data_t rd;
    e = err_cnt;
    check_val("eoc_o", eoc, 32'h0);
    check_val("irq_req_o", irq_req, 32'h0);
    check_val("fetch_enable_o", fetch_enable, 32'h0);
    check_val("core_clk_en_o", core_clk_en, 32'h0);
    check_val("busy_o", busy, 32'h0);
    for (int c = 0; c < NB_CORES; c++) begin
      check_val($sformatf("boot_addr_o[%0d]", c), boot_addr[c], BOOT_ADDR_RST);
      bus_read(CTRL_BOOT + addr_t'(4 * c), rd);
      check_val("bus_r_rdata_o", rd, BOOT_ADDR_RST);
    end
    end_test("reset values", e);
  endtask

  task automatic test_ctrl_regs();
    int         e;
    data_t      rd;
    core_mask_t fe;
    e = err_cnt;
    for (int c = 0; c < NB_CORES; c++) begin
      boot_model[c] = $urandom();
      bus_write(CTRL_BOOT + addr_t'(4 * c), boot_model[c]);
      check_val($sformatf("boot_addr_o[%0d]", c), boot_addr[c], boot_model[c]);
    end
    for (int c = 0; c < NB_CORES; c++) begin
      bus_read(CTRL_BOOT + addr_t'(4 * c), rd);
      check_val("bus_r_rdata_o", rd, boot_model[c]);
    end
    fe = core_mask_t'($urandom_range(1, 14));
    bus_write(CTRL_FETCH, 32'(fe));
    check_val("fetch_enable_o", fetch_enable, 32'(fe));
    bus_read(CTRL_FETCH, rd);
    check_val("bus_r_rdata_o", rd, 32'(fe));
    bus_write(CTRL_EOC, 32'h1);
    check_val("eoc_o", eoc, 32'h1);
    bus_read(CTRL_EOC, rd);
    check_val("bus_r_rdata_o", rd, 32'h1);
    // standalone boot input overrides the register on every core
    fetch_en = 1'b1;
    @(negedge clk);
    check_val("fetch_enable_o", fetch_enable, 32'hF);
    fetch_en = 1'b0;
    bus_write(CTRL_EOC, 32'h0);
    bus_write(CTRL_FETCH, 32'h0);
    check_val("eoc_o", eoc, 32'h0);
    check_val("fetch_enable_o", fetch_enable, 32'h0);
    end_test("control registers", e);
  endtask

  task automatic test_timer_irq();
    int         e;
    int         waited;
    data_t      rd;
    core_mask_t sel;
    e     = err_cnt;
    sel   = core_mask_t'($urandom_range(1, 15));
    cmp_n = data_t'($urandom_range(4, 20));
    write_masks(sel, 32'h01);
    bus_write(TIMER_CMP, cmp_n);
    bus_write(TIMER_CNT, 32'h0);
    // enable with clear on compare
    bus_write(TIMER_CFG, 32'h3);
    check_val("busy_o", busy, 32'h1);
    waited = 0;
    while (irq_req == '0 && waited < int'(cmp_n) + 10) begin
      @(negedge clk);
      waited++;
    end
    assert (irq_req != '0) else begin
      $display("no timer interrupt within %0d cycles", waited);
      err_cnt++;
    end
    // count reaches N, event one cycle later, pending one more
    check_val("timer irq latency", waited, cmp_n + 32'd2);
    check_val("irq_req_o", irq_req, 32'(sel));
    for (int c = 0; c < NB_CORES; c++) begin
      if (sel[c]) begin
        check_val($sformatf("irq_id_o[%0d]", c), irq_id[c], 32'h0);
      end
    end
    bus_write(TIMER_CFG, 32'h0);
    check_val("busy_o", busy, 32'h0);
    repeat (2) @(negedge clk);
    ack_irq('1, irq_id_t'(0));
    check_val("irq_req_o", irq_req, 32'h0);
    bus_read(EU_PEND, rd);
    check_val("bus_r_rdata_o", rd, 32'h0);
    write_masks('0, 32'h0);
    end_test("timer interrupt", e);
  endtask

  task automatic test_dma_sw_irq();
    int         e;
    data_t      rd;
    data_t      pend_exp;
    core_mask_t d;
    core_mask_t s;
    e = err_cnt;
    d = core_mask_t'($urandom_range(1, 15));
    s = d | core_mask_t'($urandom_range(0, 15));
    write_masks('1, 32'h0C);
    dma_events = d;
    @(negedge clk);
    dma_events = '0;
    bus_write(EU_SW, 32'(s));
    pend_exp = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      pend_exp[8*c+2] = d[c];
      pend_exp[8*c+3] = s[c];
    end
    check_val("irq_req_o", irq_req, 32'(d | s));
    for (int c = 0; c < NB_CORES; c++) begin
      if (d[c]) begin
        check_val($sformatf("irq_id_o[%0d]", c), irq_id[c], 32'd2);
      end else if (s[c]) begin
        check_val($sformatf("irq_id_o[%0d]", c), irq_id[c], 32'd3);
      end
    end
    bus_read(EU_PEND, rd);
    check_val("bus_r_rdata_o", rd, pend_exp);
    ack_irq(d, irq_id_t'(2));
    for (int c = 0; c < NB_CORES; c++) begin
      pend_exp[8*c+2] = 1'b0;
      if (s[c]) begin
        check_val($sformatf("irq_id_o[%0d]", c), irq_id[c], 32'd3);
      end
    end
    check_val("irq_req_o", irq_req, 32'(s));
    bus_read(EU_PEND, rd);
    check_val("bus_r_rdata_o", rd, pend_exp);
    ack_irq('1, irq_id_t'(3));
    check_val("irq_req_o", irq_req, 32'h0);
    write_masks('0, 32'h0);
    end_test("dma and sw events", e);
  endtask

  task automatic test_clk_gating();
    int         e;
    core_mask_t fe;
    core_mask_t sw;
    core_mask_t exp_fe;
    e = err_cnt;
    write_masks('1, 32'h08);
    for (int i = 0; i < 6; i++) begin
      fe        = core_mask_t'($urandom());
      sw        = core_mask_t'($urandom());
      core_busy = core_mask_t'($urandom());
      fetch_en  = i[0];
      bus_write(CTRL_FETCH, 32'(fe));
      bus_write(EU_SW, 32'(sw));
      exp_fe = fe | {NB_CORES{fetch_en}};
      check_val("fetch_enable_o", fetch_enable, 32'(exp_fe));
      check_val("irq_req_o", irq_req, 32'(sw));
      check_val("core_clk_en_o", core_clk_en, 32'(exp_fe & (core_busy | sw)));
      ack_irq(sw, irq_id_t'(3));
      check_val("core_clk_en_o", core_clk_en, 32'(exp_fe & core_busy));
    end
    fetch_en  = 1'b0;
    core_busy = '0;
    bus_write(CTRL_FETCH, 32'h0);
    write_masks('0, 32'h0);
    end_test("core clock gating", e);
  endtask

  task automatic test_unmapped_order();
    int    e;
    data_t rd;
    addr_t addrs[$];
    data_t exps[$];
    e = err_cnt;
    bus_read(UNMAPPED, rd);
    check_val("bus_r_rdata_o", rd, 32'hDEAD_BEEF);
    bus_write(UNMAPPED, 32'h1234_5678);
    addrs = '{CTRL_BOOT + 32'h4, TIMER_CMP, UNMAPPED, CTRL_BOOT + 32'hC, EU_PEND};
    exps  = '{boot_model[1], cmp_n, 32'hDEAD_BEEF, boot_model[3], 32'h0};
    read_in_order(addrs, exps);
    end_test("unmapped and ordering", e);
  endtask

  initial begin : watchdog
    int total;
    total = RST_CYCLES;
    foreach (TEST_CYCLES[i]) begin
      total += TEST_CYCLES[i];
    end
    #(2 * total * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not complete", 2 * total);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int unsigned total_errs;
    bus_req    = 1'b0;
    bus_add    = '0;
    bus_wen    = 1'b1;
    bus_wdata  = '0;
    bus_be     = '0;
    fetch_en   = 1'b0;
    dma_events = '0;
    core_busy  = '0;
    irq_ack    = '0;
    irq_ack_id = '0;
    err_cnt    = 0;
    fail_tests = 0;
    test_cnt   = 0;
    void'($urandom(32'h7b0f_7012));
    wait (rst_n === 1'b1);
    @(negedge clk);
    test_reset_values();
    test_ctrl_regs();
    test_timer_irq();
    test_dma_sw_irq();
    test_clk_gating();
    test_unmapped_order();
    total_errs = err_cnt + uut.sva_i.fail_cnt;
    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             test_cnt, fail_tests, err_cnt, uut.sva_i.fail_cnt);
    if (total_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- tests/cluster_periph_sva.sv
// bound protocol and interrupt checks on the cluster peripheral top-level ports
module cluster_periph_sva (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            bus_req_i,
  input cluster_periph_pkg::addr_t       bus_add_i,
  input logic                            bus_wen_i,
  input cluster_periph_pkg::data_t       bus_wdata_i,
  input cluster_periph_pkg::be_t         bus_be_i,
  input logic                            bus_gnt_o,
  input logic                            bus_r_valid_o,
  input cluster_periph_pkg::core_mask_t  irq_req_o
);
  import cluster_periph_pkg::*;

  core_mask_t  mask_nz;
  int unsigned fail_cnt;

  initial fail_cnt = 0;

  // shadow of "mask is non-zero" per core, rebuilt from bus writes to the mask registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_nz <= '0;
    end else if (bus_req_i && !bus_wen_i && bus_be_i[0] &&
                 bus_add_i[11:10] == TGT_EU && bus_add_i[5:4] == 2'b00) begin
      mask_nz[bus_add_i[3:2]] <= |bus_wdata_i[7:0];
    end
  end

  gnt_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_gnt_o == bus_req_i)
  else begin
    $error("bus_gnt_o differs from bus_req_i");
    fail_cnt++;
  end

  rvalid_after_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_req_i |=> bus_r_valid_o)
  else begin
    $error("bus_r_valid_o missing one cycle after a request");
    fail_cnt++;
  end

  rvalid_only_after_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_r_valid_o |-> $past(bus_req_i))
  else begin
    $error("bus_r_valid_o without a request in the previous cycle");
    fail_cnt++;
  end

  irq_needs_mask_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (irq_req_o & ~mask_nz) == '0)
  else begin
    $error("irq_req_o raised on a core whose mask is zero");
    fail_cnt++;
  end

endmodule

bind cluster_periph_top cluster_periph_sva sva_i (.*);

//--- tests/tb_clock_gen.sv
// testbench clock and synchronous reset generator
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  localparam int HALF_PERIOD = 5;
  localparam int RST_CYCLES  = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // release on a falling edge so the first active edge sees a settled reset
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- design/cluster_periph_top.sv
// cluster peripheral subsystem top, bus decoder with control unit, timer and event unit
module cluster_periph_top (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  bus_req_i,
  input  cluster_periph_pkg::addr_t                             bus_add_i,
  input  logic                                                  bus_wen_i,
  input  cluster_periph_pkg::data_t                             bus_wdata_i,
  input  cluster_periph_pkg::be_t                               bus_be_i,
  input  logic                                                  fetch_en_i,
  input  cluster_periph_pkg::core_mask_t                        dma_events_i,
  input  cluster_periph_pkg::core_mask_t                        core_busy_i,
  input  cluster_periph_pkg::core_mask_t                        irq_ack_i,
  input  cluster_periph_pkg::irq_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_ack_id_i,
  output logic                                                  bus_gnt_o,
  output logic                                                  bus_r_valid_o,
  output cluster_periph_pkg::data_t                             bus_r_rdata_o,
  output logic                                                  eoc_o,
  output cluster_periph_pkg::core_mask_t                        fetch_enable_o,
  output cluster_periph_pkg::addr_t [cluster_periph_pkg::NB_CORES-1:0] boot_addr_o,
  output cluster_periph_pkg::core_mask_t                        irq_req_o,
  output cluster_periph_pkg::irq_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_id_o,
  output cluster_periph_pkg::core_mask_t                        core_clk_en_o,
  output logic                                                  busy_o
);
  import cluster_periph_pkg::*;

  logic     ctrl_req;
  logic     timer_req;
  logic     eu_req;
  reg_off_t offset;
  data_t    ctrl_rdata;
  data_t    timer_rdata;
  data_t    eu_rdata;
  logic     timer_cmp_evt;
  logic     timer_ovf_evt;

  periph_bus_decoder periph_bus_decoder_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .bus_req_i     ( bus_req_i     ),
    .bus_add_i     ( bus_add_i     ),
    .bus_wen_i     ( bus_wen_i     ),
    .ctrl_rdata_i  ( ctrl_rdata    ),
    .timer_rdata_i ( timer_rdata   ),
    .eu_rdata_i    ( eu_rdata      ),
    .bus_gnt_o     ( bus_gnt_o     ),
    .bus_r_valid_o ( bus_r_valid_o ),
    .bus_r_rdata_o ( bus_r_rdata_o ),
    .ctrl_req_o    ( ctrl_req      ),
    .timer_req_o   ( timer_req     ),
    .eu_req_o      ( eu_req        ),
    .offset_o      ( offset        )
  );

  cluster_ctrl_unit cluster_ctrl_unit_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( ctrl_req       ),
    .offset_i       ( offset         ),
    .wen_i          ( bus_wen_i      ),
    .wdata_i        ( bus_wdata_i    ),
    .be_i           ( bus_be_i       ),
    .fetch_en_i     ( fetch_en_i     ),
    .rdata_o        ( ctrl_rdata     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer cluster_timer_i (
    .clk_i     ( clk_i         ),
    .rst_n_i   ( rst_n_i       ),
    .req_i     ( timer_req     ),
    .offset_i  ( offset        ),
    .wen_i     ( bus_wen_i     ),
    .wdata_i   ( bus_wdata_i   ),
    .be_i      ( bus_be_i      ),
    .rdata_o   ( timer_rdata   ),
    .cmp_evt_o ( timer_cmp_evt ),
    .ovf_evt_o ( timer_ovf_evt ),
    .busy_o    ( busy_o        )
  );

  event_unit event_unit_i (
    .clk_i           ( clk_i          ),
    .rst_n_i         ( rst_n_i        ),
    .req_i           ( eu_req         ),
    .offset_i        ( offset         ),
    .wen_i           ( bus_wen_i      ),
    .wdata_i         ( bus_wdata_i    ),
    .be_i            ( bus_be_i       ),
    .timer_cmp_evt_i ( timer_cmp_evt  ),
    .timer_ovf_evt_i ( timer_ovf_evt  ),
    .dma_events_i    ( dma_events_i   ),
    .fetch_enable_i  ( fetch_enable_o ),
    .core_busy_i     ( core_busy_i    ),
    .irq_ack_i       ( irq_ack_i      ),
    .irq_ack_id_i    ( irq_ack_id_i   ),
    .rdata_o         ( eu_rdata       ),
    .irq_req_o       ( irq_req_o      ),
    .irq_id_o        ( irq_id_o       ),
    .core_clk_en_o   ( core_clk_en_o  )
  );

endmodule

//--- design/event_unit.sv
// event unit, per-core pending and mask bits, interrupt request and id, core clock gating
module event_unit (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  req_i,
  input  cluster_periph_pkg::reg_off_t                          offset_i,
  input  logic                                                  wen_i,
  input  cluster_periph_pkg::data_t                             wdata_i,
  input  cluster_periph_pkg::be_t                               be_i,
  input  logic                                                  timer_cmp_evt_i,
  input  logic                                                  timer_ovf_evt_i,
  input  cluster_periph_pkg::core_mask_t                        dma_events_i,
  input  cluster_periph_pkg::core_mask_t                        fetch_enable_i,
  input  cluster_periph_pkg::core_mask_t                        core_busy_i,
  input  cluster_periph_pkg::core_mask_t                        irq_ack_i,
  input  cluster_periph_pkg::irq_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_ack_id_i,
  output cluster_periph_pkg::data_t                             rdata_o,
  output cluster_periph_pkg::core_mask_t                        irq_req_o,
  output cluster_periph_pkg::irq_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_id_o,
  output cluster_periph_pkg::core_mask_t                        core_clk_en_o
);
  import cluster_periph_pkg::*;

  evt_vec_t   mask_q   [NB_CORES];
  evt_vec_t   pend_q   [NB_CORES];
  evt_vec_t   set_vec  [NB_CORES];
  evt_vec_t   clr_vec  [NB_CORES];
  evt_vec_t   act_vec  [NB_CORES];
  core_mask_t sw_set;
  logic       wr_en;
  data_t      rd_word;
  data_t      wr_word;

  assign wr_en = req_i && !wen_i;

  always_comb begin
    rd_word = '0;
    if ({offset_i[3:2], 2'b00} == EU_OFF_MASK) begin
      rd_word[EVT_W-1:0] = mask_q[offset_i[1:0]];
    end else if (offset_i == EU_OFF_PEND) begin
      for (int c = 0; c < NB_CORES; c++) begin
        rd_word[EVT_W*c +: EVT_W] = pend_q[c];
      end
    end
  end

  assign wr_word = be_merge(rd_word, wdata_i, be_i);

  // software event register reads as zero, so the merge keeps only written bytes
  assign sw_set = (wr_en && offset_i == EU_OFF_SW) ? wr_word[NB_CORES-1:0] : '0;

  // event sources and acknowledge per core
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      set_vec[c]                = '0;
      set_vec[c][EVT_TIMER_CMP] = timer_cmp_evt_i;
      set_vec[c][EVT_TIMER_OVF] = timer_ovf_evt_i;
      set_vec[c][EVT_DMA]       = dma_events_i[c];
      set_vec[c][EVT_SW]        = sw_set[c];
      clr_vec[c]                = '0;
      for (int b = 0; b < EVT_W; b++) begin
        clr_vec[c][b] = irq_ack_i[c] && (irq_ack_id_i[c] == irq_id_t'(b));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < NB_CORES; c++) begin
        mask_q[c] <= '0;
        pend_q[c] <= '0;
      end
    end else begin
      // a new event wins over an acknowledge of the same bit
      for (int c = 0; c < NB_CORES; c++) begin
        pend_q[c] <= (pend_q[c] & ~clr_vec[c]) | set_vec[c];
      end
      if (wr_en && {offset_i[3:2], 2'b00} == EU_OFF_MASK) begin
        mask_q[offset_i[1:0]] <= wr_word[EVT_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_word;
    end
  end

  // lowest active index gives the id
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      act_vec[c]   = pend_q[c] & mask_q[c];
      irq_req_o[c] = |act_vec[c];
      irq_id_o[c]  = '0;
      for (int b = EVT_W - 1; b >= 0; b--) begin
        if (act_vec[c][b]) begin
          irq_id_o[c] = irq_id_t'(b);
        end
      end
    end
  end

  assign core_clk_en_o = fetch_enable_i & (core_busy_i | irq_req_o);

endmodule

//--- design/cluster_timer.sv
// cluster timer, free running cycle counter with compare and overflow events
module cluster_timer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  cluster_periph_pkg::reg_off_t  offset_i,
  input  logic                          wen_i,
  input  cluster_periph_pkg::data_t     wdata_i,
  input  cluster_periph_pkg::be_t       be_i,
  output cluster_periph_pkg::data_t     rdata_o,
  output logic                          cmp_evt_o,
  output logic                          ovf_evt_o,
  output logic                          busy_o
);
  import cluster_periph_pkg::*;

  logic  en_q;
  logic  clr_q;
  data_t count_q;
  data_t cmp_q;
  logic  cmp_evt_q;
  logic  ovf_evt_q;
  logic  wr_en;
  logic  cmp_hit;
  data_t rd_word;
  data_t wr_word;

  assign wr_en   = req_i && !wen_i;
  assign cmp_hit = en_q && (count_q == cmp_q);

  always_comb begin
    rd_word = '0;
    case (offset_i)
      TIMER_OFF_CFG: begin
        rd_word[TIMER_CFG_EN_BIT]  = en_q;
        rd_word[TIMER_CFG_CLR_BIT] = clr_q;
      end
      TIMER_OFF_CNT: rd_word = count_q;
      TIMER_OFF_CMP: rd_word = cmp_q;
      default:       rd_word = '0;
    endcase
  end

  assign wr_word = be_merge(rd_word, wdata_i, be_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q      <= 1'b0;
      clr_q     <= 1'b0;
      count_q   <= '0;
      cmp_q     <= '0;
      cmp_evt_q <= 1'b0;
      ovf_evt_q <= 1'b0;
    end else begin
      // events come from the count seen this cycle
      cmp_evt_q <= cmp_hit;
      ovf_evt_q <= en_q && (&count_q);
      if (wr_en && offset_i == TIMER_OFF_CFG) begin
        en_q  <= wr_word[TIMER_CFG_EN_BIT];
        clr_q <= wr_word[TIMER_CFG_CLR_BIT];
      end
      if (wr_en && offset_i == TIMER_OFF_CMP) begin
        cmp_q <= wr_word;
      end
      // a bus write to the counter takes priority over counting
      if (wr_en && offset_i == TIMER_OFF_CNT) begin
        count_q <= wr_word;
      end else if (cmp_hit && clr_q) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_word;
    end
  end

  assign cmp_evt_o = cmp_evt_q;
  assign ovf_evt_o = ovf_evt_q;
  assign busy_o    = en_q;

endmodule

//--- design/cluster_ctrl_unit.sv
// cluster control unit, end-of-computation flag, fetch enables and boot addresses
module cluster_ctrl_unit (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic                                                req_i,
  input  cluster_periph_pkg::reg_off_t                        offset_i,
  input  logic                                                wen_i,
  input  cluster_periph_pkg::data_t                           wdata_i,
  input  cluster_periph_pkg::be_t                             be_i,
  input  logic                                                fetch_en_i,
  output cluster_periph_pkg::data_t                           rdata_o,
  output logic                                                eoc_o,
  output cluster_periph_pkg::core_mask_t                      fetch_enable_o,
  output cluster_periph_pkg::addr_t [cluster_periph_pkg::NB_CORES-1:0] boot_addr_o
);
  import cluster_periph_pkg::*;

  logic       eoc_q;
  core_mask_t fetch_en_q;
  addr_t      boot_addr_q [NB_CORES];
  logic       wr_en;
  data_t      rd_word;
  data_t      wr_word;

  assign wr_en = req_i && !wen_i;

  // current value of the addressed register
  always_comb begin
    rd_word = '0;
    if (offset_i == CTRL_OFF_EOC) begin
      rd_word[0] = eoc_q;
    end else if (offset_i == CTRL_OFF_FETCH) begin
      rd_word[NB_CORES-1:0] = fetch_en_q;
    end else if ({offset_i[3:2], 2'b00} == CTRL_OFF_BOOT) begin
      rd_word = boot_addr_q[offset_i[1:0]];
    end
  end

  assign wr_word = be_merge(rd_word, wdata_i, be_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q      <= 1'b0;
      fetch_en_q <= '0;
      for (int c = 0; c < NB_CORES; c++) begin
        boot_addr_q[c] <= BOOT_ADDR_RST;
      end
    end else if (wr_en) begin
      if (offset_i == CTRL_OFF_EOC) begin
        eoc_q <= wr_word[0];
      end else if (offset_i == CTRL_OFF_FETCH) begin
        fetch_en_q <= wr_word[NB_CORES-1:0];
      end else if ({offset_i[3:2], 2'b00} == CTRL_OFF_BOOT) begin
        boot_addr_q[offset_i[1:0]] <= wr_word;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_word;
    end
  end

  assign eoc_o = eoc_q;

  // standalone boot input enables every core
  assign fetch_enable_o = fetch_en_q | {NB_CORES{fetch_en_i}};

  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      boot_addr_o[c] = boot_addr_q[c];
    end
  end

endmodule

//--- design/periph_bus_decoder.sv
// peripheral bus decoder, routes requests to the targets and returns the read response
module periph_bus_decoder (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          bus_req_i,
  input  cluster_periph_pkg::addr_t     bus_add_i,
  input  logic                          bus_wen_i,
  input  cluster_periph_pkg::data_t     ctrl_rdata_i,
  input  cluster_periph_pkg::data_t     timer_rdata_i,
  input  cluster_periph_pkg::data_t     eu_rdata_i,
  output logic                          bus_gnt_o,
  output logic                          bus_r_valid_o,
  output cluster_periph_pkg::data_t     bus_r_rdata_o,
  output logic                          ctrl_req_o,
  output logic                          timer_req_o,
  output logic                          eu_req_o,
  output cluster_periph_pkg::reg_off_t  offset_o
);
  import cluster_periph_pkg::*;

  tgt_t tgt;
  tgt_t rsp_tgt_q;
  logic rsp_valid_q;
  logic rsp_read_q;

  assign tgt      = tgt_t'(bus_add_i[11:10]);
  assign offset_o = reg_off_t'(bus_add_i[5:2]);

  // targets are always ready
  assign bus_gnt_o = bus_req_i;

  assign ctrl_req_o  = bus_req_i && (tgt == TGT_CTRL);
  assign timer_req_o = bus_req_i && (tgt == TGT_TIMER);
  assign eu_req_o    = bus_req_i && (tgt == TGT_EU);

  // remember who answers the request issued this cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_read_q  <= 1'b0;
      rsp_tgt_q   <= TGT_NONE;
    end else begin
      rsp_valid_q <= bus_req_i;
      if (bus_req_i) begin
        // wen high marks a read
        rsp_read_q <= bus_wen_i;
        rsp_tgt_q  <= tgt;
      end
    end
  end

  assign bus_r_valid_o = rsp_valid_q;

  // write responses carry zero
  always_comb begin
    bus_r_rdata_o = '0;
    if (rsp_valid_q && rsp_read_q) begin
      case (rsp_tgt_q)
        TGT_CTRL:  bus_r_rdata_o = ctrl_rdata_i;
        TGT_TIMER: bus_r_rdata_o = timer_rdata_i;
        TGT_EU:    bus_r_rdata_o = eu_rdata_i;
        default:   bus_r_rdata_o = UNMAPPED_RDATA;
      endcase
    end
  end

endmodule

//--- design/cluster_periph_pkg.sv
// cluster peripheral subsystem shared widths, types, address map and register constants
package cluster_periph_pkg;

  localparam int NB_CORES = 4;
  localparam int EVT_W    = 8;

  typedef logic [31:0]         addr_t;
  typedef logic [31:0]         data_t;
  typedef logic [3:0]          be_t;
  typedef logic [NB_CORES-1:0] core_mask_t;
  typedef logic [EVT_W-1:0]    evt_vec_t;
  typedef logic [4:0]          irq_id_t;
  typedef logic [3:0]          reg_off_t;
  typedef logic [1:0]          tgt_t;

  // target field, taken from address bits 11..10
  localparam tgt_t TGT_CTRL  = 2'd0;
  localparam tgt_t TGT_TIMER = 2'd1;
  localparam tgt_t TGT_EU    = 2'd2;
  localparam tgt_t TGT_NONE  = 2'd3;

  localparam data_t UNMAPPED_RDATA = 32'hDEAD_BEEF;
  localparam addr_t BOOT_ADDR_RST  = 32'h1C00_0000;

  // event source positions inside a core's event vector
  localparam int EVT_TIMER_CMP = 0;
  localparam int EVT_TIMER_OVF = 1;
  localparam int EVT_DMA       = 2;
  localparam int EVT_SW        = 3;

  // word offsets per target
  localparam reg_off_t CTRL_OFF_EOC   = 4'h0;
  localparam reg_off_t CTRL_OFF_FETCH = 4'h1;
  localparam reg_off_t CTRL_OFF_BOOT  = 4'h4;
  localparam reg_off_t TIMER_OFF_CFG  = 4'h0;
  localparam reg_off_t TIMER_OFF_CNT  = 4'h1;
  localparam reg_off_t TIMER_OFF_CMP  = 4'h2;
  localparam reg_off_t EU_OFF_MASK    = 4'h0;
  localparam reg_off_t EU_OFF_PEND    = 4'h4;
  localparam reg_off_t EU_OFF_SW      = 4'h5;

  // timer config register bits
  localparam int TIMER_CFG_EN_BIT  = 0;
  localparam int TIMER_CFG_CLR_BIT = 1;

  // merge a bus write into the current register value, byte by byte
  function automatic data_t be_merge(data_t old_val, data_t new_val, be_t be);
    data_t res;
    for (int i = 0; i < 4; i++) begin
      res[8*i +: 8] = be[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
    end
    return res;
  endfunction

endpackage
